//--- include/dump_settings.svh
`ifndef DUMP_SETTINGS_SVH
`define DUMP_SETTINGS_SVH

// DDR3 byte address of dump byte 0
`define DUMP_BASE 28'h1400000

// Last byte of the dump map
`define DUMP_LAST 10'h37F

// Width of the dump and load address
`define DUMP_AW 10

`endif

//--- rtl/msx_cfg_pkg.sv
`default_nettype none

package msx_cfg_pkg;

   // One page of the slot map
   typedef struct packed {
      logic [3:0]  typ;
      logic [3:0]  block_id;
      logic [1:0]  offset;
      logic        init;
   } slot_entry_t;

   typedef struct packed {
      logic [7:0]  block_count;
      logic [23:0] mem_offset;
   } mem_block_t;

   typedef struct packed {
      logic [3:0]  typ;
      logic [7:0]  block_id;
      logic [7:0]  block_count;
      logic [1:0]  slot;
      logic [1:0]  sub_slot;
      logic        slot_internal_mapper;
      logic [7:0]  start_block;
      logic [23:0] store_address;
   } msx_config_t;

   // Firmware store record
   typedef struct packed {
      logic [7:0]  block_count;
      logic [23:0] store_address;
      logic [7:0]  sram_block_count;
   } fw_rom_t;

   typedef logic [1:0] slot_typ_t;    // Primary slot type

endpackage

`default_nettype wire

//--- rtl/dump_map_pkg.sv
`default_nettype none

package dump_map_pkg;

   // Region of the dump map in address bits 9..8
   typedef enum logic [1:0] {
      REG_SLOT   = 2'd0,
      REG_MEMBLK = 2'd1,
      REG_CONFIG = 2'd2,
      REG_FW     = 2'd3
   } region_e;

   // Slot map region
   typedef struct packed {
      region_e     region;
      logic        is_typ;
      logic [1:0]  slot;
      logic [1:0]  sub;
      logic [1:0]  page;
      logic        half;
   } slot_view_t;

   // Memory block, config and firmware regions
   typedef struct packed {
      region_e     region;
      logic [3:0]  entry;
      logic [3:0]  field;
   } tab_view_t;

   typedef union packed {
      slot_view_t  slot_view;
      tab_view_t   tab_view;
   } dump_addr_u;

endpackage

`default_nettype wire

//--- rtl/cfg_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dump_settings.svh"

module cfg_store (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wr,
   input  logic [`DUMP_AW-1:0]       addr,
   input  logic [7:0]                data,
   output msx_cfg_pkg::slot_entry_t  slot_map[64],
   output msx_cfg_pkg::slot_typ_t    slot_typ[4],
   output msx_cfg_pkg::mem_block_t   mem_block[16],
   output msx_cfg_pkg::msx_config_t  config_tab[16],
   output msx_cfg_pkg::fw_rom_t      fw_store[8]
);
   import dump_map_pkg::*;

   dump_addr_u  a;
   logic [5:0]  slot_idx;
   logic [1:0]  typ_idx;
   logic        typ_ok;

   assign a        = addr;
   assign slot_idx = {a.slot_view.slot, a.slot_view.sub, a.slot_view.page};
   assign typ_idx  = {a.slot_view.page[0], a.slot_view.half};
   // Only 0x80..0x83 carry a slot type
   assign typ_ok   = {a.slot_view.slot, a.slot_view.sub, a.slot_view.page[1]} == 5'd0;

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_map   <= '{default: '0};
         slot_typ   <= '{default: '0};
         mem_block  <= '{default: '0};
         config_tab <= '{default: '0};
         fw_store   <= '{default: '0};
      end else if (wr) begin
         case (a.tab_view.region)
            REG_SLOT:
               if (!a.slot_view.is_typ) begin
                  if (a.slot_view.half) begin
                     slot_map[slot_idx].block_id <= data[6:3];
                     slot_map[slot_idx].offset   <= data[2:1];
                     slot_map[slot_idx].init     <= data[0];
                  end else begin
                     slot_map[slot_idx].typ <= data[3:0];
                  end
               end else if (typ_ok) begin
                  slot_typ[typ_idx] <= data[1:0];
               end
            REG_MEMBLK:
               case (a.tab_view.field)
                  4'd1: mem_block[a.tab_view.entry].block_count       <= data;
                  4'd2: mem_block[a.tab_view.entry].mem_offset[23:16] <= data;
                  4'd3: mem_block[a.tab_view.entry].mem_offset[15:8]  <= data;
                  4'd4: mem_block[a.tab_view.entry].mem_offset[7:0]   <= data;
                  default: ;                                  // Field 0 is reserved
               endcase
            REG_CONFIG:
               case (a.tab_view.field)
                  4'd0: config_tab[a.tab_view.entry].typ                  <= data[3:0];
                  4'd1: config_tab[a.tab_view.entry].block_id             <= data;
                  4'd2: config_tab[a.tab_view.entry].block_count          <= data;
                  4'd3: config_tab[a.tab_view.entry].slot                 <= data[1:0];
                  4'd4: config_tab[a.tab_view.entry].sub_slot             <= data[1:0];
                  4'd5: config_tab[a.tab_view.entry].slot_internal_mapper <= data[0];
                  4'd6: config_tab[a.tab_view.entry].start_block          <= data;
                  4'd7: config_tab[a.tab_view.entry].store_address[23:16] <= data;
                  4'd8: config_tab[a.tab_view.entry].store_address[15:8]  <= data;
                  4'd9: config_tab[a.tab_view.entry].store_address[7:0]   <= data;
                  default: ;
               endcase
            REG_FW:
               if (!a.tab_view.entry[3]) begin                // Entries 8..15 do not exist
                  case (a.tab_view.field)
                     4'd0: fw_store[a.tab_view.entry[2:0]].block_count          <= data;
                     4'd1: fw_store[a.tab_view.entry[2:0]].store_address[23:16] <= data;
                     4'd2: fw_store[a.tab_view.entry[2:0]].store_address[15:8]  <= data;
                     4'd3: fw_store[a.tab_view.entry[2:0]].store_address[7:0]   <= data;
                     4'd4: fw_store[a.tab_view.entry[2:0]].sram_block_count     <= data;
                     default: ;
                  endcase
               end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/dump_field_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "dump_settings.svh"

module dump_field_mux (
   input  logic [`DUMP_AW-1:0]       addr,
   input  msx_cfg_pkg::slot_entry_t  slot_map[64],
   input  msx_cfg_pkg::slot_typ_t    slot_typ[4],
   input  msx_cfg_pkg::mem_block_t   mem_block[16],
   input  msx_cfg_pkg::msx_config_t  config_tab[16],
   input  msx_cfg_pkg::fw_rom_t      fw_store[8],
   output logic [7:0]                byte_out
);
   import dump_map_pkg::*;

   dump_addr_u  a;
   logic [5:0]  slot_idx;
   logic [1:0]  typ_idx;
   logic [3:0]  ent;
   logic [2:0]  fw_idx;

   assign a        = addr;
   assign slot_idx = {a.slot_view.slot, a.slot_view.sub, a.slot_view.page};
   assign typ_idx  = {a.slot_view.page[0], a.slot_view.half};
   assign ent      = a.tab_view.entry;
   assign fw_idx   = a.tab_view.entry[2:0];

   always_comb begin
      byte_out = 8'd0;
      case (a.tab_view.region)
         REG_SLOT:
            if (!a.slot_view.is_typ) begin
               if (a.slot_view.half)
                  byte_out = {1'b0, slot_map[slot_idx].block_id,
                              slot_map[slot_idx].offset, slot_map[slot_idx].init};
               else
                  byte_out = {4'd0, slot_map[slot_idx].typ};
            end else if ({a.slot_view.slot, a.slot_view.sub, a.slot_view.page[1]} == 5'd0) begin
               byte_out = {6'd0, slot_typ[typ_idx]};
            end
         REG_MEMBLK:
            case (a.tab_view.field)
               4'd1: byte_out = mem_block[ent].block_count;
               4'd2: byte_out = mem_block[ent].mem_offset[23:16];
               4'd3: byte_out = mem_block[ent].mem_offset[15:8];
               4'd4: byte_out = mem_block[ent].mem_offset[7:0];
               default: byte_out = 8'd0;
            endcase
         REG_CONFIG:
            case (a.tab_view.field)
               4'd0: byte_out = {4'd0, config_tab[ent].typ};
               4'd1: byte_out = config_tab[ent].block_id;
               4'd2: byte_out = config_tab[ent].block_count;
               4'd3: byte_out = {6'd0, config_tab[ent].slot};
               4'd4: byte_out = {6'd0, config_tab[ent].sub_slot};
               4'd5: byte_out = {7'd0, config_tab[ent].slot_internal_mapper};
               4'd6: byte_out = config_tab[ent].start_block;
               4'd7: byte_out = config_tab[ent].store_address[23:16];
               4'd8: byte_out = config_tab[ent].store_address[15:8];
               4'd9: byte_out = config_tab[ent].store_address[7:0];
               default: byte_out = 8'd0;
            endcase
         REG_FW:
            if (!a.tab_view.entry[3]) begin
               case (a.tab_view.field)
                  4'd0: byte_out = fw_store[fw_idx].block_count;
                  4'd1: byte_out = fw_store[fw_idx].store_address[23:16];
                  4'd2: byte_out = fw_store[fw_idx].store_address[15:8];
                  4'd3: byte_out = fw_store[fw_idx].store_address[7:0];
                  4'd4: byte_out = fw_store[fw_idx].sram_block_count;
                  default: byte_out = 8'd0;
               endcase
            end
         default: byte_out = 8'd0;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/dump_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dump_settings.svh"

module dump_sequencer (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  logic [7:0]           byte_in,
   input  logic                 ddr3_ready,
   output logic [`DUMP_AW-1:0]  addr,
   output logic [27:0]          ddr3_addr,
   output logic [7:0]           ddr3_din,
   output logic                 ddr3_upload,
   output logic                 ddr3_wr
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_WAIT,
      S_WRITE,
      S_NEXT
   } state_t;

   state_t state;

   assign ddr3_addr = `DUMP_BASE + {{(28 - `DUMP_AW){1'b0}}, addr};

   // Payload register loads from the mux only in LOAD
   always_ff @(posedge clk) begin
      if (state == S_LOAD)
         ddr3_din <= byte_in;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= S_IDLE;
         addr        <= '0;
         ddr3_wr     <= 1'b0;
         ddr3_upload <= 1'b0;
      end else begin
         case (state)
            S_IDLE:
               if (start) begin
                  addr  <= '0;
                  state <= S_LOAD;
               end
            S_LOAD: begin
               ddr3_upload <= 1'b1;
               state       <= S_WAIT;
            end
            S_WAIT:
               if (ddr3_ready) begin
                  ddr3_wr <= 1'b1;                 // High for the WRITE cycle only
                  state   <= S_WRITE;
               end
            S_WRITE: begin
               ddr3_wr <= 1'b0;
               state   <= S_NEXT;
            end
            S_NEXT:
               if (addr == `DUMP_LAST) begin
                  ddr3_upload <= 1'b0;             // End of dump
                  state       <= S_IDLE;
               end else begin
                  addr  <= addr + 1'b1;
                  state <= S_LOAD;
               end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/msx_dump_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dump_settings.svh"

module msx_dump_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cfg_wr,
   input  logic [`DUMP_AW-1:0]  cfg_addr,
   input  logic [7:0]           cfg_data,
   input  logic                 dump_start,
   input  logic                 ddr3_ready,
   output logic [27:0]          ddr3_addr,
   output logic [7:0]           ddr3_din,
   output logic                 ddr3_upload,
   output logic                 ddr3_wr
);
   import msx_cfg_pkg::*;

   slot_entry_t          slot_map[64];
   slot_typ_t            slot_typ[4];
   mem_block_t           mem_block[16];
   msx_config_t          config_tab[16];
   fw_rom_t              fw_store[8];
   logic [`DUMP_AW-1:0]  dump_addr;
   logic [7:0]           dump_byte;

   cfg_store u_store (
      .clk        (clk),
      .reset      (reset),
      .wr         (cfg_wr),
      .addr       (cfg_addr),
      .data       (cfg_data),
      .slot_map   (slot_map),
      .slot_typ   (slot_typ),
      .mem_block  (mem_block),
      .config_tab (config_tab),
      .fw_store   (fw_store)
   );

   dump_field_mux u_mux (
      .addr       (dump_addr),
      .slot_map   (slot_map),
      .slot_typ   (slot_typ),
      .mem_block  (mem_block),
      .config_tab (config_tab),
      .fw_store   (fw_store),
      .byte_out   (dump_byte)
   );

   dump_sequencer u_seq (
      .clk         (clk),
      .reset       (reset),
      .start       (dump_start),
      .byte_in     (dump_byte),
      .ddr3_ready  (ddr3_ready),
      .addr        (dump_addr),
      .ddr3_addr   (ddr3_addr),
      .ddr3_din    (ddr3_din),
      .ddr3_upload (ddr3_upload),
      .ddr3_wr     (ddr3_wr)
   );

endmodule

`default_nettype wire

//--- bench/msx_dump_properties.sv
`timescale 1ns/1ps
`default_nettype none

module msx_dump_properties (
   input logic         clk,
   input logic         reset,
   input logic         ddr3_ready,
   input logic         ddr3_upload,
   input logic         ddr3_wr,
   input logic [27:0]  ddr3_addr,
   input logic [7:0]   ddr3_din
);

   wr_in_upload: assert property (@(posedge clk) disable iff (reset)
      ddr3_wr |-> ddr3_upload)
      else $error("ddr3_wr high while ddr3_upload is low");

   wr_one_cycle: assert property (@(posedge clk) disable iff (reset)
      ddr3_wr |=> !ddr3_wr)
      else $error("ddr3_wr held high for two cycles");

   // Ready was seen in WAIT on the edge that raised the strobe
   wr_after_ready: assert property (@(posedge clk) disable iff (reset)
      ddr3_wr |-> $past(ddr3_ready))
      else $error("ddr3_wr without ddr3_ready in the cycle before");

   wr_payload_stable: assert property (@(posedge clk) disable iff (reset)
      ddr3_wr |-> ($stable(ddr3_din) && $stable(ddr3_addr)))
      else $error("ddr3_din or ddr3_addr changed during ddr3_wr");

endmodule

bind dump_sequencer msx_dump_properties u_props (
   .clk         (clk),
   .reset       (reset),
   .ddr3_ready  (ddr3_ready),
   .ddr3_upload (ddr3_upload),
   .ddr3_wr     (ddr3_wr),
   .ddr3_addr   (ddr3_addr),
   .ddr3_din    (ddr3_din)
);

`default_nettype wire

//--- bench/msx_dump_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dump_settings.svh"

module msx_dump_tb;

   localparam int map_bytes       = `DUMP_LAST + 1;
   localparam int n_dumps         = 3;
   localparam int watchdog_cycles = n_dumps * map_bytes * 12 + 2000;

   logic                 clk;
   logic                 reset;
   logic                 cfg_wr;
   logic [`DUMP_AW-1:0]  cfg_addr;
   logic [7:0]           cfg_data;
   logic                 dump_start;
   logic                 ddr3_ready;
   logic [27:0]          ddr3_addr;
   logic [7:0]           ddr3_din;
   logic                 ddr3_upload;
   logic                 ddr3_wr;

   logic [7:0]   image[1024];     // Expected dump bytes
   logic [7:0]   mask[1024];      // Writable bits per address
   logic [31:0]  rng_state;
   logic [31:0]  rdy_state;
   logic         ready_random;
   int           wr_total = 0;
   int           dump_first;

   msx_dump_top dut (
      .clk         (clk),
      .reset       (reset),
      .cfg_wr      (cfg_wr),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .dump_start  (dump_start),
      .ddr3_ready  (ddr3_ready),
      .ddr3_addr   (ddr3_addr),
      .ddr3_din    (ddr3_din),
      .ddr3_upload (ddr3_upload),
      .ddr3_wr     (ddr3_wr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Writable bits of one dump address from the table layout
   function automatic logic [7:0] field_mask(input logic [9:0] a);
      logic [3:0] field;
      logic [7:0] m;
      field = a[3:0];
      m     = 8'h00;
      case (a[9:8])
         2'd0:
            if (!a[7])
               m = a[0] ? 8'h7F : 8'h0F;          // Second byte packs three fields
            else if (a[6:2] == 5'd0)
               m = 8'h03;
         2'd1:
            if (field >= 4'd1 && field <= 4'd4)
               m = 8'hFF;
         2'd2:
            case (field)
               4'd0: m = 8'h0F;
               4'd1, 4'd2, 4'd6, 4'd7, 4'd8, 4'd9: m = 8'hFF;
               4'd3, 4'd4: m = 8'h03;
               4'd5: m = 8'h01;
               default: m = 8'h00;
            endcase
         default:
            if (!a[7] && field <= 4'd4)
               m = 8'hFF;
      endcase
      return m;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic cfg_write(input logic [9:0] a, input logic [7:0] d);
      @(posedge clk);
      #1;
      cfg_wr   = 1'b1;
      cfg_addr = a;
      cfg_data = d;
      image[a] = d & mask[a];
      @(posedge clk);
      #1;
      cfg_wr = 1'b0;
   endtask

   task automatic random_writes(input int n);
      repeat (n) begin
         rng_state = xorshift32(rng_state);
         cfg_write(rng_state[9:0], rng_state[17:10]);
      end
   endtask

   task automatic run_dump(input logic restart_mid);
      @(posedge clk);
      #1;
      dump_first = wr_total;
      dump_start = 1'b1;
      @(posedge clk);
      #1;
      dump_start = 1'b0;
      while (!ddr3_upload) @(negedge clk);
      if (restart_mid) begin
         while (wr_total - dump_first < 300) @(negedge clk);
         @(posedge clk);
         #1;
         dump_start = 1'b1;                       // Must be ignored while busy
         @(posedge clk);
         #1;
         dump_start = 1'b0;
      end
      while (ddr3_upload) @(negedge clk);
      assert (wr_total - dump_first == map_bytes)
         else report_mismatch("write count", wr_total - dump_first, map_bytes);
   endtask

   // Check every DDR3 write against the image in address order
   always @(negedge clk) begin
      int          idx;
      logic [27:0] exp_addr;
      if (!reset && ddr3_wr) begin
         idx = wr_total - dump_first;
         assert (idx < map_bytes)
            else stop_with_failure("DDR3 write beyond the end of the dump map");
         exp_addr = `DUMP_BASE + idx;
         assert (ddr3_addr == exp_addr)
            else report_mismatch("ddr3_addr", ddr3_addr, exp_addr);
         assert (ddr3_din == image[idx[9:0]])
            else report_mismatch("ddr3_din", ddr3_din, image[idx[9:0]]);
         wr_total = wr_total + 1;
      end
   end

   initial begin
      ddr3_ready = 1'b1;
      rdy_state  = xorshift32(32'h873f);
      forever begin
         @(posedge clk);
         #1;
         if (ready_random) begin
            rdy_state  = xorshift32(rdy_state);
            ddr3_ready = rdy_state[0];
         end else begin
            ddr3_ready = 1'b1;
         end
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      stop_with_failure("Watchdog expired before the tests finished");
   end

   initial begin
      int i;
      reset        = 1'b1;
      cfg_wr       = 1'b0;
      cfg_addr     = '0;
      cfg_data     = 8'h00;
      dump_start   = 1'b0;
      ready_random = 1'b0;
      rng_state    = 32'h873f;
      dump_first   = 0;
      for (i = 0; i < 1024; i++) begin
         mask[i]  = field_mask(i[9:0]);
         image[i] = 8'h00;
      end
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      // Idle until the first start strobe
      repeat (20) begin
         @(negedge clk);
         assert (!ddr3_upload && !ddr3_wr)
            else stop_with_failure("DDR3 upload began without dump_start");
      end

      run_dump(1'b0);                             // All tables still zero
      random_writes(600);
      run_dump(1'b0);

      random_writes(150);
      cfg_write(10'h001, 8'hFF);
      cfg_write(10'h083, 8'hFE);
      cfg_write(10'h2F9, 8'h5A);
      cfg_write(10'h381, 8'hC3);                  // Reserved firmware entry
      ready_random = 1'b1;
      run_dump(1'b1);
      ready_random = 1'b0;

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- msx_dump.f
+incdir+include
rtl/msx_cfg_pkg.sv
rtl/dump_map_pkg.sv
rtl/cfg_store.sv
rtl/dump_field_mux.sv
rtl/dump_sequencer.sv
rtl/msx_dump_top.sv
bench/msx_dump_properties.sv
bench/msx_dump_tb.sv

//--- build.sh
#!/bin/sh
# Build and run the msx_dump testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f msx_dump.f --top-module msx_dump_tb -o msx_dump_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/msx_dump_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0
